/* compile.f */
+incdir+.
pool_cfg_pkg.sv
pool_data_pkg.sv
pool_stage_if.sv
pool_apb_regs.sv
pool_buffer_mem.sv
pool_addr_gen.sv
pool_window_max.sv
pool_writer.sv
pool_top.sv
tb_pool.sv

/* pool_addr_gen.sv */
// window read address generator
`timescale 1ns/1ps
`include "pool_defs.svh"

module pool_addr_gen (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_start,
    input  pool_cfg_pkg::pool_cfg_t i_cfg,
    output logic                    o_rd_en,
    output logic [`POOL_ADDR_W-1:0] o_rd_addr,
    pool_stage_if.source            rd_if
);
    import pool_cfg_pkg::*;
    import pool_data_pkg::*;

    localparam int ADDR_W = `POOL_ADDR_W;
    localparam int DIM_W  = `POOL_DIM_W;

    logic              active;
    logic [1:0]        slot;
    logic [DIM_W-1:0]  col;
    logic [DIM_W-1:0]  row;
    logic [DIM_W-1:0]  ch;
    logic [ADDR_W:0]   win_addr;  // top-left element, spare bit catches overrun
    logic [ADDR_W-1:0] dst_addr;
    logic [ADDR_W:0]   win_step;
    logic [ADDR_W:0]   rd_full;
    logic              issue;
    logic              last_col;
    logic              last_row;
    logic              last_ch;
    logic              final_rd;
    logic              tag_valid;
    pool_rd_tag_t      tag_q;

    assign issue    = active && rd_if.ready;
    assign last_col = (col == (i_cfg.width >> 1) - DIM_W'(1));
    assign last_row = (row == (i_cfg.height >> 1) - DIM_W'(1));
    assign last_ch  = (ch == i_cfg.channels - DIM_W'(1));
    assign final_rd = (slot == 2'd3) && last_col && last_row && last_ch;

    // past the row end the next window sits one map row further down
    assign win_step = last_col ? (ADDR_W+1)'(i_cfg.width) + (ADDR_W+1)'(2)
                               : (ADDR_W+1)'(2);

    // raster order inside the window
    assign rd_full = win_addr + (slot[1] ? (ADDR_W+1)'(i_cfg.width) : '0)
                     + (ADDR_W+1)'(slot[0]);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            active    <= 1'b0;
            slot      <= '0;
            col       <= '0;
            row       <= '0;
            ch        <= '0;
            tag_valid <= 1'b0;
        end else begin
            tag_valid <= issue;
            if (i_start) begin
                active <= 1'b1;
                slot   <= '0;
                col    <= '0;
                row    <= '0;
                ch     <= '0;
            end else if (issue) begin
                slot <= slot + 2'd1;
                if (slot == 2'd3) begin
                    col <= last_col ? '0 : col + DIM_W'(1);
                    if (last_col)
                        row <= last_row ? '0 : row + DIM_W'(1);
                    if (last_col && last_row)
                        ch <= ch + DIM_W'(1);
                end
                if (final_rd)
                    active <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            win_addr <= {1'b0, i_cfg.src_base};
            dst_addr <= i_cfg.dst_base;
        end else if (issue && slot == 2'd3) begin
            win_addr <= win_addr + win_step;
            dst_addr <= dst_addr + ADDR_W'(1);
        end
        if (issue) begin
            tag_q.slot     <= slot;
            tag_q.last     <= final_rd;
            tag_q.dst_addr <= dst_addr;
        end
    end

    assign o_rd_en       = issue;
    assign o_rd_addr     = rd_full[ADDR_W-1:0];
    assign rd_if.valid   = tag_valid;  // lines up with memory read data
    assign rd_if.payload = tag_q;

    assert property (@(posedge i_clk) disable iff (i_rst)
        o_rd_en |-> rd_full < `POOL_MEM_DEPTH);

endmodule

/* pool_apb_regs.sv */
// pooling APB registers
`timescale 1ns/1ps
`include "pool_defs.svh"

module pool_apb_regs (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_psel,
    input  logic                      i_penable,
    input  logic                      i_pwrite,
    input  logic [15:0]               i_paddr,
    input  logic [31:0]               i_pwdata,
    output logic [31:0]               o_prdata,
    output logic                      o_pready,
    output logic                      o_pslverr,
    output logic                      o_irq,
    output pool_cfg_pkg::pool_cfg_t   o_cfg,
    output logic                      o_start,
    output logic                      o_busy,
    input  logic                      i_done,
    output logic                      o_host_en,
    output logic                      o_host_we,
    output logic [`POOL_ADDR_W-1:0]   o_host_addr,
    output logic [`POOL_DATA_W-1:0]   o_host_wdata,
    input  logic [`POOL_DATA_W-1:0]   i_host_rdata
);
    import pool_cfg_pkg::*;

    pool_cfg_t   cfg_q;
    logic        irq_en;
    logic        busy;
    logic        done;
    logic        error;
    logic        win_hit;
    logic        access;
    logic        wr_acc;
    logic        start_ok;
    logic        mapped;
    logic [31:0] reg_rdata;

    assign win_hit = (i_paddr[15:12] == MEM_WIN_BASE[15:12]);
    assign access  = i_psel && i_penable;
    assign wr_acc  = access && i_pwrite && !win_hit;

    // even, nonzero dimensions and an idle engine
    assign start_ok = !busy && (cfg_q.width != '0) && !cfg_q.width[0]
                      && (cfg_q.height != '0) && !cfg_q.height[0]
                      && (cfg_q.channels != '0);
    assign o_start = wr_acc && (i_paddr == REG_CTRL) && i_pwdata[0] && start_ok;

    // window reads go out in setup so data is back for the access phase
    assign o_host_en    = i_psel && win_hit && !busy && (i_pwrite ? i_penable : !i_penable);
    assign o_host_we    = i_pwrite;
    assign o_host_addr  = i_paddr[`POOL_ADDR_W+1:2];
    assign o_host_wdata = i_pwdata[`POOL_DATA_W-1:0];

    always_comb begin
        mapped    = 1'b1;
        reg_rdata = '0;
        case (i_paddr)
            REG_CTRL:     reg_rdata = {29'b0, cfg_q.mode, irq_en, 1'b0};
            REG_STATUS:   reg_rdata = {29'b0, error, done, busy};
            REG_DIMS:     reg_rdata = {16'b0, cfg_q.height, cfg_q.width};
            REG_CHANNELS: reg_rdata = 32'(cfg_q.channels);
            REG_SRC_BASE: reg_rdata = 32'(cfg_q.src_base);
            REG_DST_BASE: reg_rdata = 32'(cfg_q.dst_base);
            default:      mapped = 1'b0;
        endcase
    end

    assign o_prdata  = win_hit ? 32'(i_host_rdata) : reg_rdata;
    assign o_pready  = 1'b1;
    assign o_pslverr = access && (win_hit ? busy : !mapped);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            cfg_q  <= '0;
            irq_en <= 1'b0;
            busy   <= 1'b0;
            done   <= 1'b0;
            error  <= 1'b0;
        end else begin
            if (i_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (wr_acc) begin
                case (i_paddr)
                    REG_CTRL: begin
                        irq_en <= i_pwdata[1];
                        if (!busy)
                            cfg_q.mode <= pool_mode_e'(i_pwdata[2]);
                        if (i_pwdata[0] && start_ok) begin
                            busy  <= 1'b1;
                            done  <= 1'b0;
                            error <= 1'b0;
                        end else if (i_pwdata[0]) begin
                            error <= 1'b1;  // refused start
                        end
                    end
                    REG_STATUS: begin
                        if (i_pwdata[1])
                            done <= 1'b0;
                        if (i_pwdata[2])
                            error <= 1'b0;
                    end
                    REG_DIMS: begin
                        if (!busy) begin
                            cfg_q.width  <= i_pwdata[7:0];
                            cfg_q.height <= i_pwdata[15:8];
                        end
                    end
                    REG_CHANNELS: if (!busy) cfg_q.channels <= i_pwdata[`POOL_DIM_W-1:0];
                    REG_SRC_BASE: if (!busy) cfg_q.src_base <= i_pwdata[`POOL_ADDR_W-1:0];
                    REG_DST_BASE: if (!busy) cfg_q.dst_base <= i_pwdata[`POOL_ADDR_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    assign o_cfg  = cfg_q;
    assign o_busy = busy;
    assign o_irq  = done && irq_en;

    // done only arrives while a run is in progress
    assert property (@(posedge i_clk) disable iff (i_rst) i_done |-> busy);

endmodule

/* pool_buffer_mem.sv */
// feature map buffer memory
`timescale 1ns/1ps
`include "pool_defs.svh"

module pool_buffer_mem (
    input  logic                    i_clk,
    input  logic                    i_busy,
    input  logic                    i_host_en,
    input  logic                    i_host_we,
    input  logic [`POOL_ADDR_W-1:0] i_host_addr,
    input  logic [`POOL_DATA_W-1:0] i_host_wdata,
    output logic [`POOL_DATA_W-1:0] o_host_rdata,
    input  logic                    i_rd_en,
    input  logic [`POOL_ADDR_W-1:0] i_rd_addr,
    output logic [`POOL_DATA_W-1:0] o_rd_data,
    input  logic                    i_wr_en,
    input  logic [`POOL_ADDR_W-1:0] i_wr_addr,
    input  logic [`POOL_DATA_W-1:0] i_wr_data
);

    logic [`POOL_DATA_W-1:0] mem [0:`POOL_MEM_DEPTH-1];
    logic                    we;
    logic                    re;
    logic [`POOL_ADDR_W-1:0] waddr;
    logic [`POOL_ADDR_W-1:0] raddr;
    logic [`POOL_DATA_W-1:0] wdata;
    logic [`POOL_DATA_W-1:0] rdata_q;

    // engine owns both ports during a run
    assign we    = i_busy ? i_wr_en   : (i_host_en && i_host_we);
    assign waddr = i_busy ? i_wr_addr : i_host_addr;
    assign wdata = i_busy ? i_wr_data : i_host_wdata;
    assign re    = i_busy ? i_rd_en   : (i_host_en && !i_host_we);
    assign raddr = i_busy ? i_rd_addr : i_host_addr;

    always_ff @(posedge i_clk) begin
        if (we)
            mem[waddr] <= wdata;
        if (re)
            rdata_q <= mem[raddr];
    end

    assign o_host_rdata = rdata_q;
    assign o_rd_data    = rdata_q;

    assert property (@(posedge i_clk) !i_busy |-> !(i_rd_en || i_wr_en));

endmodule

/* pool_cfg_pkg.sv */
// pooling run configuration
`include "pool_defs.svh"

package pool_cfg_pkg;

    typedef enum logic {
        MODE_UNSIGNED = 1'b0,
        MODE_SIGNED   = 1'b1
    } pool_mode_e;

    typedef struct packed {
        logic [`POOL_DIM_W-1:0]  width;
        logic [`POOL_DIM_W-1:0]  height;
        logic [`POOL_DIM_W-1:0]  channels;
        logic [`POOL_ADDR_W-1:0] src_base;
        logic [`POOL_ADDR_W-1:0] dst_base;
        pool_mode_e              mode;
    } pool_cfg_t;

    // apb byte offsets
    localparam logic [15:0] REG_CTRL     = 16'h0000;
    localparam logic [15:0] REG_STATUS   = 16'h0004;
    localparam logic [15:0] REG_DIMS     = 16'h0008;  // height in [15:8], width in [7:0]
    localparam logic [15:0] REG_CHANNELS = 16'h000C;
    localparam logic [15:0] REG_SRC_BASE = 16'h0010;
    localparam logic [15:0] REG_DST_BASE = 16'h0014;
    localparam logic [15:0] MEM_WIN_BASE = 16'h1000;  // one word per 4 bytes

endpackage

/* pool_data_pkg.sv */
// pooling pipeline payloads
`include "pool_defs.svh"

package pool_data_pkg;

    typedef logic [`POOL_DATA_W-1:0] pool_elem_t;

    // rides along with each engine read
    typedef struct packed {
        logic [1:0]              slot;      // position in the 2x2 window
        logic                    last;      // final window of the run
        logic [`POOL_ADDR_W-1:0] dst_addr;
    } pool_rd_tag_t;

    // one window maximum headed for the result area
    typedef struct packed {
        logic [`POOL_ADDR_W-1:0] addr;
        pool_elem_t              value;
        logic                    last;
    } pool_result_t;

endpackage

/* pool_defs.svh */
// pooling block parameters
`ifndef POOL_DEFS_SVH
`define POOL_DEFS_SVH

// element width in bits
`define POOL_DATA_W 16

// buffer word address width
`define POOL_ADDR_W 10

// buffer memory depth in words
`define POOL_MEM_DEPTH 1024

// width, height and channel fields
`define POOL_DIM_W 8

`endif

/* pool_stage_if.sv */
// valid/ready stage handshake
`timescale 1ns/1ps

interface pool_stage_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     ready;
    payload_t payload;  // steady while valid and not ready

    modport source (
        output valid,
        output payload,
        input  ready
    );

    modport sink (
        input  valid,
        input  payload,
        output ready
    );

endinterface

/* pool_top.sv */
// pooling block top level
`timescale 1ns/1ps
`include "pool_defs.svh"

module pool_top (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [15:0] i_paddr,
    input  logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    output logic        o_pready,
    output logic        o_pslverr,
    output logic        o_irq
);
    import pool_cfg_pkg::*;
    import pool_data_pkg::*;

    pool_cfg_t               cfg;
    logic                    start;
    logic                    busy;
    logic                    done;
    logic                    host_en;
    logic                    host_we;
    logic [`POOL_ADDR_W-1:0] host_addr;
    logic [`POOL_DATA_W-1:0] host_wdata;
    logic [`POOL_DATA_W-1:0] host_rdata;
    logic                    rd_en;
    logic [`POOL_ADDR_W-1:0] rd_addr;
    pool_elem_t              rd_data;
    logic                    wr_en;
    logic [`POOL_ADDR_W-1:0] wr_addr;
    pool_elem_t              wr_data;

    pool_stage_if #(.payload_t(pool_rd_tag_t)) rd_if ();
    pool_stage_if #(.payload_t(pool_result_t)) res_if ();

    pool_apb_regs pool_apb_regs_inst (
        .i_clk, .i_rst, .i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
        .o_prdata, .o_pready, .o_pslverr, .o_irq,
        .o_cfg(cfg), .o_start(start), .o_busy(busy), .i_done(done),
        .o_host_en(host_en), .o_host_we(host_we), .o_host_addr(host_addr),
        .o_host_wdata(host_wdata), .i_host_rdata(host_rdata)
    );

    pool_buffer_mem pool_buffer_mem_inst (
        .i_clk, .i_busy(busy),
        .i_host_en(host_en), .i_host_we(host_we), .i_host_addr(host_addr),
        .i_host_wdata(host_wdata), .o_host_rdata(host_rdata),
        .i_rd_en(rd_en), .i_rd_addr(rd_addr), .o_rd_data(rd_data),
        .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data)
    );

    pool_addr_gen pool_addr_gen_inst (
        .i_clk, .i_rst, .i_start(start), .i_cfg(cfg),
        .o_rd_en(rd_en), .o_rd_addr(rd_addr), .rd_if(rd_if.source)
    );

    pool_window_max pool_window_max_inst (
        .i_clk, .i_rst, .i_mode(cfg.mode), .i_rd_data(rd_data),
        .rd_if(rd_if.sink), .res_if(res_if.source)
    );

    pool_writer pool_writer_inst (
        .i_clk, .i_rst, .res_if(res_if.sink),
        .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data), .o_done(done)
    );

endmodule

/* pool_window_max.sv */
// 2x2 window max reduction
`timescale 1ns/1ps

module pool_window_max (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  pool_cfg_pkg::pool_mode_e  i_mode,
    input  pool_data_pkg::pool_elem_t i_rd_data,
    pool_stage_if.sink                rd_if,
    pool_stage_if.source              res_if
);
    import pool_cfg_pkg::*;
    import pool_data_pkg::*;

    pool_rd_tag_t tag;
    pool_elem_t   acc;       // running max of the open window
    pool_elem_t   win_max;
    pool_result_t res_q;
    logic         res_valid;
    logic         data_gt;
    logic [1:0]   prev_slot;

    assign tag = rd_if.payload;

    always_comb begin
        if (i_mode == MODE_SIGNED)
            data_gt = $signed(i_rd_data) > $signed(acc);
        else
            data_gt = i_rd_data > acc;
        win_max = (tag.slot == 2'd0 || data_gt) ? i_rd_data : acc;
    end

    // ready only throttles issue, a read already in flight is always taken
    always_ff @(posedge i_clk) begin
        if (rd_if.valid)
            acc <= win_max;
        if (rd_if.valid && tag.slot == 2'd3) begin
            res_q.addr  <= tag.dst_addr;
            res_q.value <= win_max;
            res_q.last  <= tag.last;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            res_valid <= 1'b0;
            prev_slot <= 2'd3;
        end else begin
            if (rd_if.valid)
                prev_slot <= tag.slot;
            if (rd_if.valid && tag.slot == 2'd3)
                res_valid <= 1'b1;
            else if (res_if.ready)
                res_valid <= 1'b0;
        end
    end

    assign rd_if.ready    = !res_valid || res_if.ready;  // hold off while result stuck
    assign res_if.valid   = res_valid;
    assign res_if.payload = res_q;

    // slots arrive in order, slot 0 after slot 3 or reset
    assert property (@(posedge i_clk) disable iff (i_rst)
        rd_if.valid |-> tag.slot == prev_slot + 2'd1);

endmodule

/* pool_writer.sv */
// result writer
`timescale 1ns/1ps
`include "pool_defs.svh"

module pool_writer (
    input  logic                      i_clk,
    input  logic                      i_rst,
    pool_stage_if.sink                res_if,
    output logic                      o_wr_en,
    output logic [`POOL_ADDR_W-1:0]   o_wr_addr,
    output pool_data_pkg::pool_elem_t o_wr_data,
    output logic                      o_done
);
    import pool_data_pkg::*;

    pool_result_t res;
    logic         done_q;

    assign res          = res_if.payload;
    assign res_if.ready = 1'b1;  // never stalls

    // write lands on the accepting edge
    assign o_wr_en   = res_if.valid;
    assign o_wr_addr = res.addr;
    assign o_wr_data = res.value;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst)
            done_q <= 1'b0;
        else
            done_q <= res_if.valid && res.last;  // one cycle after final write
    end

    assign o_done = done_q;

endmodule

/* tb_pool.sv */
// pooling block testbench
`timescale 1ns/1ps
`include "pool_defs.svh"

module tb_pool;
    import pool_cfg_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int LOADED_ELEMS = 16 + 72 + 4;  // input elements over all tests
    localparam int WATCHDOG_CYC = 50 * LOADED_ELEMS + 2000;
    localparam int POLL_LIMIT   = 300;

    logic        i_clk;
    logic        i_rst;
    logic        i_psel;
    logic        i_penable;
    logic        i_pwrite;
    logic [15:0] i_paddr;
    logic [31:0] i_pwdata;
    logic [31:0] o_prdata;
    logic        o_pready;
    logic        o_pslverr;
    logic        o_irq;

    logic [`POOL_DATA_W-1:0] shadow [0:`POOL_MEM_DEPTH-1];  // host view of loaded data
    logic [31:0] lcg_state;
    int          err_count;
    int          tests_passed;
    int          tests_failed;
    int          start_errs;
    logic [31:0] rd;
    logic        err;

    pool_top pool_top_inst (.*);

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    // reference max of one 2x2 window, straight from the loaded data
    function automatic logic [15:0] ref_window_max(input int src, input int w, input int h,
                                                   input int ch, input int r, input int c,
                                                   input logic smode);
        int          base;
        logic [15:0] e [4];
        logic [15:0] m;
        base = src + ch * w * h + 2 * r * w + 2 * c;
        e[0] = shadow[base];
        e[1] = shadow[base + 1];
        e[2] = shadow[base + w];
        e[3] = shadow[base + w + 1];
        m = e[0];
        for (int i = 1; i < 4; i++) begin
            if (smode ? ($signed(e[i]) > $signed(m)) : (e[i] > m))
                m = e[i];
        end
        return m;
    endfunction

    task automatic check_eq(input string test, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("ERROR %s %s: expected %h actual %h", test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [31:0] data,
                             output logic slverr);
        @(posedge i_clk);
        #2;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b1;
        i_paddr   = addr;
        i_pwdata  = data;
        @(posedge i_clk);
        #2 i_penable = 1'b1;
        @(negedge i_clk);
        slverr = o_pslverr;
        @(posedge i_clk);
        #2;
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic apb_read(input logic [15:0] addr, output logic [31:0] data,
                            output logic slverr);
        @(posedge i_clk);
        #2;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = addr;
        @(posedge i_clk);
        #2 i_penable = 1'b1;
        @(negedge i_clk);  // mid access phase
        data   = o_prdata;
        slverr = o_pslverr;
        @(posedge i_clk);
        #2;
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic load_word(input string test, input int addr, input logic [15:0] data);
        logic e;
        apb_write(MEM_WIN_BASE + 16'(addr * 4), 32'(data), e);
        shadow[addr] = data;
        check_eq(test, "load pslverr", 0, e);
    endtask

    task automatic wait_done(input string test);
        logic [31:0] st;
        logic        e;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[1] && polls < POLL_LIMIT) begin
            apb_read(REG_STATUS, st, e);
            polls++;
        end
        if (!st[1]) begin
            $display("%s: done never set, the run did not complete", test);
            err_count++;
        end
        check_eq(test, "busy after done", 0, st[0]);
    endtask

    // channel-major, row-major result area
    task automatic check_results(input string test, input int src, input int dst,
                                 input int w, input int h, input int chs, input logic smode);
        logic [31:0] d;
        logic        e;
        int          idx;
        idx = dst;
        for (int ch = 0; ch < chs; ch++)
            for (int r = 0; r < h / 2; r++)
                for (int c = 0; c < w / 2; c++) begin
                    apb_read(MEM_WIN_BASE + 16'(idx * 4), d, e);
                    check_eq(test, $sformatf("result[%0d]", idx),
                             32'(ref_window_max(src, w, h, ch, r, c, smode)), d);
                    idx++;
                end
    endtask

    task automatic end_test(input string test, input int errs_before);
        if (err_count == errs_before) begin
            $display("%s: PASS", test);
            tests_passed++;
        end else begin
            $display("%s: FAIL with %0d errors", test, err_count - errs_before);
            tests_failed++;
        end
    endtask

    // protocol checks on every cycle
    always @(negedge i_clk) begin
        if (!i_rst) begin
            assert (o_pready)
            else begin
                $display("pready dropped low, access could not complete");
                err_count++;
            end
            assert (o_pslverr == 1'b0 || (i_psel && i_penable))
            else begin
                $display("pslverr raised outside an access phase");
                err_count++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        i_clk        = 1'b0;
        i_rst        = 1'b1;
        i_psel       = 1'b0;
        i_penable    = 1'b0;
        i_pwrite     = 1'b0;
        i_paddr      = '0;
        i_pwdata     = '0;
        lcg_state    = 32'h3105;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (3) @(posedge i_clk);
        #2 i_rst = 1'b0;

        start_errs = err_count;
        apb_read(REG_STATUS, rd, err);
        check_eq("reset_regs", "status", 0, rd);
        check_eq("reset_regs", "irq", 0, o_irq);
        apb_write(REG_DIMS, 32'h0406, err);
        apb_read(REG_DIMS, rd, err);
        check_eq("reset_regs", "dims", 32'h0406, rd);
        apb_write(REG_CHANNELS, 32'd3, err);
        apb_read(REG_CHANNELS, rd, err);
        check_eq("reset_regs", "channels", 32'd3, rd);
        apb_write(REG_SRC_BASE, 32'h040, err);
        apb_read(REG_SRC_BASE, rd, err);
        check_eq("reset_regs", "src_base", 32'h040, rd);
        apb_write(REG_DST_BASE, 32'h200, err);
        apb_read(REG_DST_BASE, rd, err);
        check_eq("reset_regs", "dst_base", 32'h200, rd);
        apb_write(REG_CTRL, 32'h6, err);  // irq_en and signed mode, no start
        apb_read(REG_CTRL, rd, err);
        check_eq("reset_regs", "ctrl", 32'h6, rd);
        end_test("reset_regs", start_errs);

        // 4x4 unsigned with large and sign-bit values
        start_errs = err_count;
        load_word("unsigned_4x4", 0, 16'd1);
        load_word("unsigned_4x4", 1, 16'd9);
        load_word("unsigned_4x4", 2, 16'd3);
        load_word("unsigned_4x4", 3, 16'd4);
        load_word("unsigned_4x4", 4, 16'd5);
        load_word("unsigned_4x4", 5, 16'd2);
        load_word("unsigned_4x4", 6, 16'h8000);
        load_word("unsigned_4x4", 7, 16'd7);
        load_word("unsigned_4x4", 8, 16'hFFFF);
        load_word("unsigned_4x4", 9, 16'd0);
        load_word("unsigned_4x4", 10, 16'd10);
        load_word("unsigned_4x4", 11, 16'd11);
        load_word("unsigned_4x4", 12, 16'd12);
        load_word("unsigned_4x4", 13, 16'd13);
        load_word("unsigned_4x4", 14, 16'd14);
        load_word("unsigned_4x4", 15, 16'h7FFF);
        apb_write(REG_DIMS, 32'h0404, err);
        apb_write(REG_CHANNELS, 32'd1, err);
        apb_write(REG_SRC_BASE, 32'h000, err);
        apb_write(REG_DST_BASE, 32'h100, err);
        apb_write(REG_CTRL, 32'h1, err);
        wait_done("unsigned_4x4");
        check_results("unsigned_4x4", 0, 'h100, 4, 4, 1, 1'b0);
        apb_write(REG_STATUS, 32'h2, err);
        end_test("unsigned_4x4", start_errs);

        // 6x4, three channels, signed compare
        start_errs = err_count;
        for (int i = 0; i < 72; i++)
            load_word("signed_6x4x3", 'h040 + i, lcg_next());
        load_word("signed_6x4x3", 'h1FF, 16'hA5A5);  // guards around the result area
        load_word("signed_6x4x3", 'h212, 16'h5A5A);
        apb_write(REG_DIMS, 32'h0406, err);
        apb_write(REG_CHANNELS, 32'd3, err);
        apb_write(REG_SRC_BASE, 32'h040, err);
        apb_write(REG_DST_BASE, 32'h200, err);
        apb_write(REG_CTRL, 32'h5, err);
        wait_done("signed_6x4x3");
        check_results("signed_6x4x3", 'h040, 'h200, 6, 4, 3, 1'b1);
        apb_read(MEM_WIN_BASE + 16'('h1FF * 4), rd, err);
        check_eq("signed_6x4x3", "word below results", 32'hA5A5, rd);
        apb_read(MEM_WIN_BASE + 16'('h212 * 4), rd, err);
        check_eq("signed_6x4x3", "word above results", 32'h5A5A, rd);
        apb_write(REG_STATUS, 32'h2, err);
        end_test("signed_6x4x3", start_errs);

        start_errs = err_count;
        for (int i = 0; i < 4; i++)
            load_word("interrupt", 'h300 + i, lcg_next());
        apb_write(REG_DIMS, 32'h0202, err);
        apb_write(REG_CHANNELS, 32'd1, err);
        apb_write(REG_SRC_BASE, 32'h300, err);
        apb_write(REG_DST_BASE, 32'h310, err);
        apb_write(REG_CTRL, 32'h3, err);  // irq_en with start
        check_eq("interrupt", "irq while busy", 0, o_irq);
        wait_done("interrupt");
        @(negedge i_clk);
        check_eq("interrupt", "irq after done", 1, o_irq);
        check_results("interrupt", 'h300, 'h310, 2, 2, 1, 1'b0);
        apb_write(REG_STATUS, 32'h2, err);
        apb_read(REG_STATUS, rd, err);
        check_eq("interrupt", "status after clear", 0, rd);
        check_eq("interrupt", "irq after clear", 0, o_irq);
        apb_write(REG_CTRL, 32'h0, err);
        end_test("interrupt", start_errs);

        start_errs = err_count;
        apb_write(REG_DIMS, 32'h0405, err);  // odd width
        apb_write(REG_CTRL, 32'h1, err);
        apb_read(REG_STATUS, rd, err);
        check_eq("errors", "status after odd start", 32'h4, rd);
        apb_write(REG_STATUS, 32'h4, err);
        apb_read(16'h0020, rd, err);
        check_eq("errors", "unmapped pslverr", 1, err);
        apb_write(REG_DIMS, 32'h0406, err);
        apb_write(REG_SRC_BASE, 32'h040, err);
        apb_write(REG_DST_BASE, 32'h200, err);
        apb_write(REG_CTRL, 32'h5, err);
        apb_read(MEM_WIN_BASE + 16'('h040 * 4), rd, err);
        check_eq("errors", "window read pslverr", 1, err);
        apb_write(MEM_WIN_BASE + 16'('h040 * 4), 32'h1234, err);
        check_eq("errors", "window write pslverr", 1, err);
        apb_read(REG_STATUS, rd, err);
        check_eq("errors", "status during run", 32'h1, rd);
        wait_done("errors");
        apb_read(MEM_WIN_BASE + 16'('h040 * 4), rd, err);
        check_eq("errors", "word after refused write", 32'(shadow['h040]), rd);
        apb_write(REG_STATUS, 32'h2, err);
        end_test("errors", start_errs);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (err_count == 0 && tests_failed == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
